//--- include/rope_consts.svh
// constants for geometry, frame timing, step sizes, item values and the register map
`ifndef ROPE_CONSTS_SVH
`define ROPE_CONSTS_SVH

// clock cycles per game frame
`define ROPE_FRAME_TICKS 4

// rope pivot on screen
`define ROPE_ORIGIN_X 160
`define ROPE_ORIGIN_Y 45

// rope length in pixels
`define ROPE_LEN_MIN 20
`define ROPE_LEN_STEP 6

// index 0 is 15 degrees, index 30 is 165, 5 degrees per index
`define ROPE_ANGLE_STEPS 31
`define ROPE_ANGLE_REST 15

// frames per retract step, empty and loaded
`define ROPE_RETRACT_FRAMES 2
`define ROPE_LOADED_FRAMES 5

`define SCREEN_W 320
`define SCREEN_H 240
`define ROPE_EDGE_MARGIN 2
`define ITEM_SIZE 16
`define ITEM_SLOTS 16

`define SCORE_STONE 10
`define SCORE_GOLD 20
`define SCORE_DIAMOND 50

// item slot n sits at byte address 4n
`define AXIL_ADDR_COUNT 8'h40
`define AXIL_ADDR_SCORE 8'h44

`endif

//--- verilog/rope_pkg.sv
// item record, coordinate, angle, length, slot, score and hook phase types
package rope_pkg;

    typedef enum logic [1:0] {
        kind_stone   = 2'd0,
        kind_gold    = 2'd1,
        kind_diamond = 2'd2
    } item_kind_t;

    // one table entry, same layout for the host and the controller
    typedef struct packed {
        logic [8:0] x;
        logic [3:0] rsvd_hi;
        logic [7:0] y;
        logic [6:0] rsvd_lo;
        item_kind_t kind;
        logic       visible;
        logic       grabbed;
    } item_word_t;

    typedef logic [9:0] coord_t;
    typedef logic [4:0] angle_idx_t;
    typedef logic [9:0] rope_len_t;
    typedef logic [3:0] slot_idx_t;
    // wraps at 1024
    typedef logic [9:0] score_t;

    typedef enum logic [1:0] {
        phase_idle    = 2'd0,
        phase_swing   = 2'd1,
        phase_extend  = 2'd2,
        phase_retract = 2'd3
    } hook_phase_t;

endpackage

//--- verilog/go_pulse.sv
// one-frame launch pulse from the rising edge of the go key
`timescale 1ns/1ps
`include "rope_consts.svh"

module go_pulse (
    input  logic clock,
    input  logic resetn,
    input  logic go_key,
    output logic go
);
    localparam int CW = $clog2(`ROPE_FRAME_TICKS + 1);
    localparam logic [CW-1:0] LAST_TICK = CW'(`ROPE_FRAME_TICKS - 1);

    logic          key_q;
    logic [CW-1:0] tick_cnt;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            key_q    <= 1'b0;
            go       <= 1'b0;
            tick_cnt <= '0;
        end else begin
            key_q <= go_key;
            if (go) begin
                // edges seen while the pulse runs are dropped
                if (tick_cnt == LAST_TICK) begin
                    go       <= 1'b0;
                    tick_cnt <= '0;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end else if (go_key && !key_q) begin
                go <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/rope_endpoint.sv
// trig table lookup and registered rope end point
`timescale 1ns/1ps
`include "rope_consts.svh"

module rope_endpoint import rope_pkg::*; (
    input  logic       clock,
    input  logic       resetn,
    input  angle_idx_t angle_idx,
    input  rope_len_t  rope_len,
    output coord_t     end_x,
    output coord_t     end_y
);
    localparam coord_t ORIGIN_X = coord_t'(`ROPE_ORIGIN_X);
    localparam coord_t ORIGIN_Y = coord_t'(`ROPE_ORIGIN_Y);

    // entry is {cos sign, cos magnitude, sin magnitude}, magnitudes x256
    logic [18:0] trig_rom [`ROPE_ANGLE_STEPS];
    logic [18:0] entry;
    logic [17:0] x_prod;
    logic [17:0] y_prod;
    coord_t      x_term;
    coord_t      y_term;

    initial begin
        $readmemh("trig_table.hex", trig_rom);
    end

    assign entry  = trig_rom[angle_idx];
    assign x_prod = rope_len * entry[17:9];
    assign y_prod = rope_len * entry[8:0];

    // drop the 8 fraction bits
    assign x_term = x_prod[17:8];
    assign y_term = y_prod[17:8];

    always_ff @(posedge clock) begin
        if (!resetn) begin
            end_x <= ORIGIN_X;
            end_y <= ORIGIN_Y;
        end else begin
            // sign set means right of the origin
            end_x <= entry[18] ? ORIGIN_X + x_term : ORIGIN_X - x_term;
            end_y <= ORIGIN_Y + y_term;
        end
    end

endmodule

//--- verilog/item_store.sv
// item table, item count and score readback behind an AXI4-Lite slave
`timescale 1ns/1ps
`include "rope_consts.svh"

module item_store import rope_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    input  slot_idx_t   scan_addr,
    output item_word_t  scan_item,
    input  logic        item_wr_en,
    input  slot_idx_t   item_wr_addr,
    input  item_word_t  item_wr_data,
    output logic [4:0]  item_count,
    input  score_t      score
);
    item_word_t  items [`ITEM_SLOTS];
    logic        wr_accept;
    logic        rd_accept;
    logic        host_item_wr;
    slot_idx_t   host_slot;
    logic [31:0] host_word;

    // address and data are taken together, one response outstanding
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign bresp     = 2'b00;

    assign rd_accept = arvalid && !rvalid;
    assign arready   = !rvalid;
    assign rresp     = 2'b00;

    assign host_slot    = awaddr[5:2];
    assign host_item_wr = wr_accept && (awaddr < `AXIL_ADDR_COUNT);

    // unstrobed lanes keep the stored bytes
    always_comb begin
        host_word = items[host_slot];
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                host_word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clock) begin
        // controller wins a same-slot collision
        if (host_item_wr && !(item_wr_en && item_wr_addr == host_slot)) begin
            items[host_slot] <= host_word;
        end
        if (item_wr_en) begin
            items[item_wr_addr] <= item_wr_data;
        end
        scan_item <= items[scan_addr];
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            item_count <= '0;
        end else begin
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            // count saturates at the table size
            if (wr_accept && awaddr == `AXIL_ADDR_COUNT) begin
                item_count <= (wdata > `ITEM_SLOTS) ? 5'(`ITEM_SLOTS) : wdata[4:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rd_accept) begin
            if (araddr < `AXIL_ADDR_COUNT) begin
                rdata <= items[araddr[5:2]];
            end else if (araddr == `AXIL_ADDR_COUNT) begin
                rdata <= {27'd0, item_count};
            end else if (araddr == `AXIL_ADDR_SCORE) begin
                rdata <= {22'd0, score};
            end else begin
                rdata <= '0;
            end
        end
    end

endmodule

//--- verilog/rope_controller.sv
// hook FSM with swing, extend, bounds test, item scan, retract and score
`timescale 1ns/1ps
`include "rope_consts.svh"

module rope_controller import rope_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    input  logic        enable,
    input  logic        go,
    input  coord_t      end_x,
    input  coord_t      end_y,
    input  item_word_t  scan_item,
    input  logic [4:0]  item_count,
    output hook_phase_t phase,
    output angle_idx_t  angle_idx,
    output rope_len_t   rope_len,
    output slot_idx_t   scan_addr,
    output logic        item_wr_en,
    output slot_idx_t   item_wr_addr,
    output item_word_t  item_wr_data,
    output score_t      score
);
    localparam int FW = $clog2(`ROPE_FRAME_TICKS + 1);
    localparam rope_len_t  LEN_MIN    = rope_len_t'(`ROPE_LEN_MIN);
    localparam rope_len_t  LEN_STEP   = rope_len_t'(`ROPE_LEN_STEP);
    // last step lands at or below MIN + 1
    localparam rope_len_t  LEN_DONE   = LEN_MIN + LEN_STEP + rope_len_t'(1);
    localparam angle_idx_t ANGLE_REST = angle_idx_t'(`ROPE_ANGLE_REST);
    localparam angle_idx_t ANGLE_TOP  = angle_idx_t'(`ROPE_ANGLE_STEPS - 1);
    localparam coord_t     X_LO       = coord_t'(`ROPE_EDGE_MARGIN);
    localparam coord_t     X_HI       = coord_t'(`SCREEN_W - `ROPE_EDGE_MARGIN);
    localparam coord_t     Y_HI       = coord_t'(`SCREEN_H - `ROPE_EDGE_MARGIN);
    localparam coord_t     ITEM_SZ    = coord_t'(`ITEM_SIZE);

    logic [FW-1:0] frame_cnt;
    logic          frame_tick;
    logic          dir_down;
    logic          loaded;
    logic [2:0]    ret_frames;
    logic [2:0]    ret_last;
    logic [1:0]    settle_cnt;
    logic          scan_req;
    logic          chk_valid;
    slot_idx_t     chk_slot;
    slot_idx_t     grab_slot;
    item_word_t    grab_word;
    logic          busy;
    logic          out_of_bounds;
    logic          hit;
    coord_t        item_x;
    coord_t        item_y;

    function automatic score_t kind_value(item_kind_t kind);
        case (kind)
            kind_stone:   return score_t'(`SCORE_STONE);
            kind_gold:    return score_t'(`SCORE_GOLD);
            kind_diamond: return score_t'(`SCORE_DIAMOND);
            default:      return '0;
        endcase
    endfunction

    assign frame_tick = frame_cnt == FW'(`ROPE_FRAME_TICKS - 1);
    assign ret_last   = loaded ? 3'(`ROPE_LOADED_FRAMES - 1) : 3'(`ROPE_RETRACT_FRAMES - 1);
    // an extend step waits for the end point test and the scan
    assign busy       = (settle_cnt != 2'd0) || scan_req || chk_valid;

    assign out_of_bounds = (end_x < X_LO) || (end_x >= X_HI) || (end_y >= Y_HI);
    assign item_x = coord_t'(scan_item.x);
    assign item_y = coord_t'(scan_item.y);
    assign hit    = scan_item.visible && !scan_item.grabbed
                 && (item_x < end_x) && (end_x <= item_x + ITEM_SZ)
                 && (item_y < end_y) && (end_y <= item_y + ITEM_SZ);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            frame_cnt  <= '0;
            phase      <= phase_idle;
            angle_idx  <= ANGLE_REST;
            rope_len   <= LEN_MIN;
            dir_down   <= 1'b1;
            loaded     <= 1'b0;
            ret_frames <= '0;
            settle_cnt <= '0;
            scan_req   <= 1'b0;
            chk_valid  <= 1'b0;
            scan_addr  <= '0;
            item_wr_en <= 1'b0;
            score      <= '0;
        end else begin
            frame_cnt  <= frame_tick ? '0 : frame_cnt + 1'b1;
            item_wr_en <= 1'b0;
            chk_valid  <= scan_req;
            chk_slot   <= scan_addr;

            if (frame_tick && !enable) begin
                phase      <= phase_idle;
                angle_idx  <= ANGLE_REST;
                rope_len   <= LEN_MIN;
                dir_down   <= 1'b1;
                loaded     <= 1'b0;
                settle_cnt <= '0;
                scan_req   <= 1'b0;
                chk_valid  <= 1'b0;
            end else begin
                case (phase)
                    phase_idle: begin
                        if (enable) begin
                            phase <= phase_swing;
                        end
                    end
                    phase_swing: begin
                        if (frame_tick && go) begin
                            phase <= phase_extend;
                        end else if (frame_tick && dir_down) begin
                            angle_idx <= angle_idx - 1'b1;
                            dir_down  <= angle_idx != angle_idx_t'(1);
                        end else if (frame_tick) begin
                            angle_idx <= angle_idx + 1'b1;
                            dir_down  <= angle_idx == ANGLE_TOP - 1'b1;
                        end
                    end
                    phase_extend: begin
                        if (frame_tick && !busy) begin
                            rope_len   <= rope_len + LEN_STEP;
                            settle_cnt <= 2'd2;
                        end
                        if (settle_cnt != 2'd0) begin
                            settle_cnt <= settle_cnt - 1'b1;
                        end
                        // end point now reflects the new length
                        if (settle_cnt == 2'd1) begin
                            if (out_of_bounds) begin
                                phase      <= phase_retract;
                                loaded     <= 1'b0;
                                ret_frames <= '0;
                            end else if (item_count != 5'd0) begin
                                scan_req  <= 1'b1;
                                scan_addr <= '0;
                            end
                        end
                        if (scan_req) begin
                            if ({1'b0, scan_addr} + 5'd1 >= item_count) begin
                                scan_req <= 1'b0;
                            end else begin
                                scan_addr <= scan_addr + 1'b1;
                            end
                        end
                        // first matching slot wins
                        if (chk_valid && hit) begin
                            phase        <= phase_retract;
                            loaded       <= 1'b1;
                            ret_frames   <= '0;
                            scan_req     <= 1'b0;
                            chk_valid    <= 1'b0;
                            grab_slot    <= chk_slot;
                            grab_word    <= scan_item;
                            item_wr_en   <= 1'b1;
                            item_wr_addr <= chk_slot;
                            item_wr_data <= scan_item;
                            item_wr_data.grabbed <= 1'b1;
                        end
                    end
                    phase_retract: begin
                        if (frame_tick && ret_frames != ret_last) begin
                            ret_frames <= ret_frames + 1'b1;
                        end else if (frame_tick && rope_len > LEN_DONE) begin
                            ret_frames <= '0;
                            rope_len   <= rope_len - LEN_STEP;
                        end else if (frame_tick) begin
                            // back at the top, swing on in the old direction
                            ret_frames <= '0;
                            rope_len   <= LEN_MIN;
                            phase      <= phase_swing;
                            loaded     <= 1'b0;
                            if (loaded) begin
                                score        <= score + kind_value(grab_word.kind);
                                item_wr_en   <= 1'b1;
                                item_wr_addr <= grab_slot;
                                item_wr_data <= grab_word;
                                item_wr_data.visible <= 1'b0;
                                item_wr_data.grabbed <= 1'b1;
                            end
                        end
                    end
                    default: begin
                        phase <= phase_idle;
                    end
                endcase
            end
        end
    end

endmodule

//--- verilog/rope_top.sv
// top level joining key pulse, end point, item store and hook FSM
`timescale 1ns/1ps

module rope_top import rope_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    input  logic        go_key,
    input  logic        enable,
    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output hook_phase_t phase,
    output angle_idx_t  angle_idx,
    output rope_len_t   rope_len,
    output coord_t      end_x,
    output coord_t      end_y,
    output score_t      score
);
    logic       go;
    slot_idx_t  scan_addr;
    item_word_t scan_item;
    logic       item_wr_en;
    slot_idx_t  item_wr_addr;
    item_word_t item_wr_data;
    logic [4:0] item_count;

    // all port names match the nets above
    go_pulse go_pulse_inst (.*);

    rope_endpoint rope_endpoint_inst (.*);

    item_store item_store_inst (.*);

    rope_controller rope_controller_inst (.*);

endmodule

//--- verif/rope_tb.sv
// testbench with clock, reset, AXI tasks, reference end points, monitor and watchdog
`timescale 1ns/1ps
`include "rope_consts.svh"

module rope_tb import rope_pkg::*; ();

    localparam int MAX_STEPS    = `SCREEN_H / `ROPE_LEN_STEP;
    // extend may lose a frame per step while scanning and loaded retract is the slowest
    localparam int TRIP_FRAMES  = MAX_STEPS * (`ROPE_LOADED_FRAMES + 2);
    localparam int SWING_FRAMES = 2 * `ROPE_ANGLE_STEPS;
    localparam int AXI_FRAMES   = 60;
    localparam int TIMEOUT_NS   = (SWING_FRAMES + 2 * TRIP_FRAMES + AXI_FRAMES)
                                  * `ROPE_FRAME_TICKS * 100;
    // in bounds for every angle
    localparam int HIT_LEN      = `ROPE_LEN_MIN + 12 * `ROPE_LEN_STEP;

    logic        clock;
    logic        resetn;
    logic        go_key;
    logic        enable;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    hook_phase_t phase;
    angle_idx_t  angle_idx;
    rope_len_t   rope_len;
    coord_t      end_x;
    coord_t      end_y;
    score_t      score;

    logic [18:0] ref_trig [`ROPE_ANGLE_STEPS];
    logic        mon_valid;
    logic        seen_low;
    logic        seen_high;
    angle_idx_t  prev_angle;
    rope_len_t   prev_len;
    hook_phase_t prev_phase;
    logic [19:0] mon_end;

    rope_top rope_top_inst (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // {end_x, end_y} for a given angle index and length
    function automatic logic [19:0] expected_end(input int angle, input int len);
        logic [18:0] e;
        int          cos_term;
        int          sin_term;
        int          ex;
        int          ey;
        e        = ref_trig[angle];
        cos_term = (len * int'(e[17:9])) / 256;
        sin_term = (len * int'(e[8:0])) / 256;
        ex       = e[18] ? `ROPE_ORIGIN_X + cos_term : `ROPE_ORIGIN_X - cos_term;
        ey       = `ROPE_ORIGIN_Y + sin_term;
        return {ex[9:0], ey[9:0]};
    endfunction

    function automatic bit out_of_bounds(input logic [19:0] pt);
        return (pt[19:10] < `ROPE_EDGE_MARGIN)
            || (pt[19:10] >= `SCREEN_W - `ROPE_EDGE_MARGIN)
            || (pt[9:0] >= `SCREEN_H - `ROPE_EDGE_MARGIN);
    endfunction

    function automatic score_t kind_points(input item_kind_t kind);
        case (kind)
            kind_stone:   return score_t'(`SCORE_STONE);
            kind_gold:    return score_t'(`SCORE_GOLD);
            kind_diamond: return score_t'(`SCORE_DIAMOND);
            default:      return '0;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got === want) else begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, want);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic require_rule(input bit ok, input string what);
        assert (ok) else begin
            $display("ERROR: %s", what);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    // bready stays low for a random number of cycles
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        int delay;
        delay   = $urandom_range(3, 0);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do begin
            @(negedge clock);
        end while (!awready);
        compare_value("wready", wready, 32'h1);
        @(posedge clock);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (delay) begin
            @(negedge clock);
            compare_value("bvalid", bvalid, 32'h1);
            @(posedge clock);
            #1;
        end
        bready = 1'b1;
        @(negedge clock);
        compare_value("bvalid", bvalid, 32'h1);
        compare_value("bresp", bresp, 32'h0);
        @(posedge clock);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
        int delay;
        delay   = $urandom_range(3, 0);
        araddr  = addr;
        arvalid = 1'b1;
        do begin
            @(negedge clock);
        end while (!arready);
        @(posedge clock);
        #1;
        arvalid = 1'b0;
        @(negedge clock);
        compare_value("rvalid", rvalid, 32'h1);
        data = rdata;
        repeat (delay) begin
            @(posedge clock);
            #1;
            @(negedge clock);
            compare_value("rvalid", rvalid, 32'h1);
            compare_value("rdata", rdata, data);
        end
        @(posedge clock);
        #1;
        rready = 1'b1;
        @(negedge clock);
        compare_value("rvalid", rvalid, 32'h1);
        compare_value("rdata", rdata, data);
        compare_value("rresp", rresp, 32'h0);
        @(posedge clock);
        #1;
        rready = 1'b0;
    endtask

    task automatic wait_phase(input hook_phase_t want);
        do begin
            @(negedge clock);
        end while (phase != want);
        @(posedge clock);
        #1;
    endtask

    // hold the key two cycles and wait for the rope to extend
    task automatic press_go();
        go_key = 1'b1;
        repeat (2) begin
            @(posedge clock);
            #1;
        end
        go_key = 1'b0;
        wait_phase(phase_extend);
    endtask

    // end point, length and angle rules checked every cycle
    always @(negedge clock) begin
        if (!resetn) begin
            mon_valid = 1'b0;
            seen_low  = 1'b0;
            seen_high = 1'b0;
        end else begin
            require_rule(angle_idx <= `ROPE_ANGLE_STEPS - 1, "angle index left 0..30");
            require_rule(rope_len >= `ROPE_LEN_MIN
                         && (rope_len - `ROPE_LEN_MIN) % `ROPE_LEN_STEP == 0,
                         "rope length is not 20 plus a multiple of 6");
            if (mon_valid) begin
                mon_end = expected_end(prev_angle, prev_len);
                compare_value("end_x", end_x, mon_end[19:10]);
                compare_value("end_y", end_y, mon_end[9:0]);
                if (angle_idx != prev_angle) begin
                    require_rule(angle_idx == prev_angle + 1'b1
                                 || angle_idx + 1'b1 == prev_angle,
                                 "angle index moved by more than one step");
                end
                if (phase == phase_retract && prev_phase == phase_retract) begin
                    require_rule(rope_len <= prev_len, "rope grew during retract");
                end
            end
            if (angle_idx == 0) begin
                seen_low = 1'b1;
            end
            if (angle_idx == `ROPE_ANGLE_STEPS - 1) begin
                seen_high = 1'b1;
            end
            prev_angle = angle_idx;
            prev_len   = rope_len;
            prev_phase = phase;
            mon_valid  = 1'b1;
        end
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] word;
        logic [7:0]  addr;
        int          count;
        score_t      score_before;
        score_t      score_want;
        logic [19:0] hit_end;
        int          rx;
        int          ry;
        item_word_t  target;
        item_word_t  far_item;
        item_word_t  taken;

        void'($urandom(32'h94ea_4d04));
        resetn  = 1'b0;
        go_key  = 1'b0;
        enable  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hf;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        $readmemh("trig_table.hex", ref_trig);
        repeat (10) @(posedge clock);
        #1;
        resetn = 1'b1;

        compare_value("phase", phase, phase_idle);
        compare_value("rope_len", rope_len, `ROPE_LEN_MIN);
        compare_value("angle_idx", angle_idx, `ROPE_ANGLE_REST);
        compare_value("score", score, 32'h0);
        compare_value("bvalid", bvalid, 32'h0);
        compare_value("rvalid", rvalid, 32'h0);

        // free swing to both ends
        enable = 1'b1;
        do begin
            @(negedge clock);
        end while (!(seen_low && seen_high));
        compare_value("phase", phase, phase_swing);
        @(posedge clock);
        #1;

        // register file
        repeat (6) begin
            addr = 8'($urandom_range(15, 0) * 4);
            word = $urandom;
            axi_write(addr, word);
            axi_read(addr, rd);
            compare_value("rdata", rd, word);
        end
        axi_write(`AXIL_ADDR_COUNT, 32'd20);
        axi_read(`AXIL_ADDR_COUNT, rd);
        compare_value("rdata", rd, `ITEM_SLOTS);
        count = $urandom_range(16, 0);
        axi_write(`AXIL_ADDR_COUNT, count);
        axi_read(`AXIL_ADDR_COUNT, rd);
        compare_value("rdata", rd, count);
        axi_read(`AXIL_ADDR_SCORE, rd);
        compare_value("rdata", rd, 32'h0);
        axi_read(8'h80, rd);
        compare_value("rdata", rd, 32'h0);
        axi_write(`AXIL_ADDR_COUNT, 32'd0);

        // with an empty table the rope runs to the screen edge
        score_before = score;
        press_go();
        wait_phase(phase_retract);
        require_rule(out_of_bounds(expected_end(angle_idx, rope_len)),
                     "rope retracted while its end was still on screen");
        require_rule(!out_of_bounds(expected_end(angle_idx, rope_len - `ROPE_LEN_STEP)),
                     "rope kept extending after its end left the screen");
        wait_phase(phase_swing);
        compare_value("rope_len", rope_len, `ROPE_LEN_MIN);
        compare_value("score", score, score_before);

        // item placed where the frozen angle will carry the hook
        press_go();
        hit_end = expected_end(angle_idx, HIT_LEN);
        rx = $urandom_range(15, 0);
        ry = $urandom_range(15, 0);
        target = '0;
        target.x = 9'(hit_end[19:10] - 10'd1 - 10'(rx));
        target.y = 8'(hit_end[9:0] - 10'd1 - 10'(ry));
        target.kind = item_kind_t'($urandom_range(2, 0));
        target.visible = 1'b1;
        // placed above the origin where the hook never gets
        far_item = '0;
        far_item.x = 9'($urandom_range(300, 0));
        far_item.y = 8'($urandom_range(10, 0));
        far_item.kind = kind_gold;
        far_item.visible = 1'b1;
        score_before = score;
        score_want = score_t'(score_before + kind_points(target.kind));
        axi_write(8'h00, target);
        axi_write(8'h04, far_item);
        axi_write(`AXIL_ADDR_COUNT, 32'd2);
        wait_phase(phase_retract);
        wait_phase(phase_swing);
        compare_value("rope_len", rope_len, `ROPE_LEN_MIN);
        compare_value("score", score, score_want);
        taken = target;
        taken.visible = 1'b0;
        taken.grabbed = 1'b1;
        axi_read(8'h00, rd);
        compare_value("rdata", rd, taken);
        axi_read(8'h04, rd);
        compare_value("rdata", rd, far_item);
        axi_read(`AXIL_ADDR_SCORE, rd);
        compare_value("rdata", rd, score_want);

        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: timeout, the tests did not finish in time");
        $display("STATUS: FAIL");
        $fatal(1);
    end

endmodule

//--- trig_table.hex
// columns: cos sign (bit 18), cos magnitude x256 (bits 17..9), sin magnitude x256 (bits 8..0)
// one line per angle index, index 0 is 15 degrees and index 30 is 165 degrees
5EE42
5E258
5D06C
5BC80
5A493
588A5
56AB5
54AC4
526D2
500DE
4D8E8
4B0F1
484F7
458FC
42CFF
40100
02CFF
058FC
084F7
0B0F1
0D8E8
100DE
126D2
14AC4
16AB5
188A5
1A493
1BC80
1D06C
1E258
1EE42

//--- vlog.f
+incdir+include
verilog/rope_pkg.sv
verilog/go_pulse.sv
verilog/rope_endpoint.sv
verilog/item_store.sv
verilog/rope_controller.sv
verilog/rope_top.sv
verif/rope_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rope controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rope_tb -f vlog.f -o rope_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rope_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
    exit 0
fi
exit 1
